/* build.f */
rtl/wexPkg.sv
rtl/bundleStreamIf.sv
rtl/wbBundleWriter.sv
rtl/bundleQueue.sv
rtl/laneDecode.sv
rtl/bundleDecode.sv
rtl/wexDecodeTop.sv
dv/wexDecode_assertions.sv
dv/wexDecodeTb.sv

/* Makefile */
# Verilator build and run of the WEX decode stage testbench

VERILATOR ?= verilator
TOP ?= wexDecodeTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_PATTERN ?= \*\*\* PASSED \*\*\*

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '$(PASS_PATTERN)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/wexDecodeTb.sv */
/*
 Table-driven testbench for wexDecodeTop.
 Expected lanes come from a model of the op layout and routing rules.
 Output stalls come from an xorshift generator with a fixed seed.
 */
module wexDecodeTb;
	timeunit 1ns;
	timeprecision 100ps;
	import wexPkg::*;

	typedef struct packed {
		opWordT w0;
		opWordT w1;
		opWordT w2;
		logic wxe;
		opCountT count;
	} caseT;

	typedef struct packed {
		regIdT n;
		regIdT m;
		regIdT o;
		immT imm;
		uCmdT cmd;
		uIxtT ixt;
	} laneT;

	typedef struct packed {
		opCountT count;
		laneT [2:0] lane;
	} expT;

	typedef enum logic [1:0] {STALL_FREE, STALL_HOLD, STALL_RANDOM} stallT;

	function automatic opWordT mkOp(logic [4:0] pfx, logic flag, regIdT n, regIdT m,
		regIdT o, logic [7:0] opc);
		return {pfx, flag, n, m, o, opc};
	endfunction

	localparam int NCASES = 10;
	localparam int PASSES = 3;
	localparam int TIMEOUT = 1000;
	localparam int RELEASE_DELAY = 12;
	localparam logic [4:0] SC = 5'b01010;	// Neither predicated nor unconditional
	localparam logic [4:0] PR = PFX_PRED[5:1];
	localparam logic [4:0] UN = PFX_UNCOND[5:1];

	localparam opWordT OP_S0 = mkOp(SC, 1'b0, 1, 2, 3, 8'h11);
	localparam opWordT OP_S1 = mkOp(SC, 1'b0, 4, 5, 6, 8'h22);
	localparam opWordT OP_S2 = mkOp(SC, 1'b0, 7, 8, 9, 8'h33);
	localparam opWordT OP_W0 = mkOp(UN, 1'b1, 10, 11, 12, 8'h41);
	localparam opWordT OP_W1 = mkOp(UN, 1'b1, 13, 14, 15, 8'h42);
	localparam opWordT OP_PT = mkOp(PR, 1'b0, 16, 17, 40, 8'h83);	// Negative imm
	localparam opWordT OP_PF = mkOp(PR, 1'b1, 20, 21, 50, 8'hc4);
	localparam opWordT OP_U0 = mkOp(UN, 1'b0, 22, 23, 24, 8'h05);

	// word0, word1, word2, wxe, expected op count
	localparam caseT CASES [NCASES] = '{
		'{OP_S0, OP_S1, OP_S2, 1'b1, 2'd1},
		'{OP_W0, OP_S1, OP_S2, 1'b1, 2'd2},
		'{OP_W0, OP_W1, OP_PT, 1'b1, 2'd3},
		'{OP_W0, OP_S1, OP_S2, 1'b0, 2'd1},
		'{OP_W0, OP_W1, OP_PT, 1'b0, 2'd1},
		'{OP_PT, OP_S1, OP_S2, 1'b0, 2'd1},
		'{OP_PF, OP_S0, OP_S1, 1'b0, 2'd1},
		'{OP_U0, OP_W1, OP_S2, 1'b1, 2'd1},	// Only word1 flagged
		'{OP_W0, OP_PF, OP_S0, 1'b1, 2'd2},
		'{OP_W0, OP_W1, OP_S0, 1'b1, 2'd3}
	};

	logic clock;
	logic arstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [1:0] wbAdr;
	opWordT wbDatW;
	opWordT wbDatR;
	logic wbAck;
	logic decodeReady;
	logic decodeValid;
	opCountT opCount;
	regIdT regAM, regAO, regAN;
	regIdT regBM, regBO, regBN;
	regIdT regCM, regCO, regCN;
	immT immA, immB, immC;
	uCmdT uCmdA, uCmdB, uCmdC;
	uIxtT uIxtA, uIxtB, uIxtC;

	expT expQ [$];
	int pushed = 0;
	int popped = 0;
	logic curWxe = 1'b0;
	stallT stallMode = STALL_FREE;
	logic [31:0] rngState = 32'h7215_ac0f;

	wexDecodeTop UUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic laneT decodeOp(opWordT w);
		laneT l;
		condT cond;
		cond = COND_AL;
		if (w[31:27] == PR) begin
			cond = w[26] ? COND_CF : COND_CT;
		end
		l.n = w[25:20];
		l.m = w[19:14];
		l.o = w[13:8];
		l.imm = 33'($signed(w[13:0]));
		l.cmd = {cond, w[5:0]};
		l.ixt = w[7:0];
		return l;
	endfunction

	function automatic laneT idleLane(regIdT m, regIdT o);
		return '{GR_ZZR, m, o, '0, '0, '0};
	endfunction

	function automatic expT modelBundle(caseT c);
		expT e;
		logic wA;
		logic wB;
		wA = c.wxe && (c.w0[31:26] == {UN, 1'b1});
		wB = c.wxe && (c.w1[31:26] == {UN, 1'b1});
		e.count = c.count;
		if (wA && wB) begin
			e.lane[0] = decodeOp(c.w2);
			e.lane[1] = decodeOp(c.w1);
			e.lane[2] = decodeOp(c.w0);
		end else if (wA) begin
			e.lane[0] = decodeOp(c.w1);	// Chain ends in lane A
			e.lane[1] = decodeOp(c.w0);
			e.lane[2] = idleLane(c.w0[25:20], c.w1[25:20]);
		end else begin
			e.lane[0] = decodeOp(c.w0);
			e.lane[1] = idleLane(GR_ZZR, c.w0[25:20]);
			e.lane[2] = idleLane(GR_ZZR, c.w0[25:20]);
		end
		return e;
	endfunction

	task automatic stopOnError(string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic checkReg(string name, regIdT got, regIdT exp);
		if (got !== exp) begin
			stopOnError($sformatf("** Error at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic checkImm(string name, immT got, immT exp);
		if (got !== exp) begin
			stopOnError($sformatf("** Error at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic checkCmd(string lane, uCmdT gotCmd, uCmdT expCmd, uIxtT gotIxt,
		uIxtT expIxt);
		if (gotCmd !== expCmd) begin
			stopOnError($sformatf("** Error at %0t: uCmd%s got %h expected %h",
				$time, lane, gotCmd, expCmd));
		end
		if (gotIxt !== expIxt) begin
			stopOnError($sformatf("** Error at %0t: uIxt%s got %h expected %h",
				$time, lane, gotIxt, expIxt));
		end
	endtask

	task automatic checkCount(opCountT got, opCountT exp);
		if (got !== exp) begin
			stopOnError($sformatf("** Error at %0t: opCount got %0d expected %0d",
				$time, got, exp));
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			stopOnError($sformatf("** Error at %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic checkLane(string lane, laneT e, regIdT n, regIdT m, regIdT o, immT imm,
		uCmdT cmd, uIxtT ixt);
		checkReg({"reg", lane, "N"}, n, e.n);
		checkReg({"reg", lane, "M"}, m, e.m);
		checkReg({"reg", lane, "O"}, o, e.o);
		checkImm({"imm", lane}, imm, e.imm);
		checkCmd(lane, cmd, e.cmd, ixt, e.ixt);
	endtask

	// Returns at the falling edge inside the ack cycle
	task automatic waitAck(output int waits);
		waits = 0;
		do begin
			@(negedge clock);
			waits++;
			if (waits > TIMEOUT) begin
				stopOnError($sformatf("Timeout: no Wishbone ack for address %0d", wbAdr));
			end
		end while (!wbAck);
	endtask

	task automatic releaseBus();
		@(negedge clock);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(logic [1:0] adr, opWordT data, output int waits);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbDatW = data;
		waitAck(waits);
		releaseBus();
	endtask

	task automatic wbRead(logic [1:0] adr, output opWordT data);
		int waits;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = adr;
		waitAck(waits);
		data = wbDatR;
		releaseBus();
	endtask

	task automatic applyCase(int idx, output int commitWaits);
		caseT c;
		opWordT ctrl;
		int waits;
		c = CASES[idx];
		if (c.wxe != curWxe) begin
			wbWrite(ADDR_CTRL, {31'b0, c.wxe}, waits);
			wbRead(ADDR_CTRL, ctrl);
			checkFlag("wxe readback", ctrl[0], c.wxe);
			curWxe = c.wxe;
		end
		wbWrite(2'd0, c.w0, waits);
		wbWrite(2'd1, c.w1, waits);
		expQ.push_back(modelBundle(c));
		wbWrite(2'd2, c.w2, commitWaits);
		pushed++;
	endtask

	task automatic waitDrained();
		int waits;
		waits = 0;
		while (popped != pushed) begin
			@(negedge clock);
			waits++;
			if (waits > TIMEOUT) begin
				stopOnError("Timeout: decoded output did not drain");
			end
		end
	endtask

	task automatic produce();
		int waits;
		opWordT ctrl;
		for (int p = 0; p < PASSES; p++) begin
			if (p == 1) begin
				waitDrained();
				stallMode = STALL_HOLD;
			end
			for (int i = 0; i < NCASES; i++) begin
				if (p == 1 && i == QUEUE_DEPTH + 1) begin
					// Queue plus output register hold every bundle so far
					wbRead(ADDR_CTRL, ctrl);
					checkFlag("queue full", ctrl[1], 1'b1);
					fork
						begin
							repeat (RELEASE_DELAY) @(negedge clock);
							stallMode = STALL_RANDOM;
						end
					join_none
					applyCase(i, waits);
					checkFlag("commit ack delayed", waits > 1, 1'b1);
				end else begin
					applyCase(i, waits);
				end
			end
		end
	endtask

	task automatic consume();
		expT e;
		int waits;
		for (int k = 0; k < PASSES * NCASES; k++) begin
			waits = 0;
			do begin
				@(negedge clock);
				case (stallMode)
					STALL_HOLD: decodeReady = 1'b0;
					STALL_FREE: decodeReady = 1'b1;
					default: begin
						rngState = xorshift(rngState);
						decodeReady = rngState[7];
					end
				endcase
				waits++;
				if (waits > TIMEOUT) begin
					stopOnError("Timeout: no decoded bundle came out of the DUT");
				end
			end while (!(decodeValid && decodeReady));
			if (expQ.size() == 0) begin
				stopOnError("DUT produced a bundle that was never written");
			end
			e = expQ.pop_front();
			checkCount(opCount, e.count);
			checkLane("A", e.lane[0], regAN, regAM, regAO, immA, uCmdA, uIxtA);
			checkLane("B", e.lane[1], regBN, regBM, regBO, immB, uCmdB, uIxtB);
			checkLane("C", e.lane[2], regCN, regCM, regCO, immC, uCmdC, uIxtC);
			popped++;
		end
		@(negedge clock);
		decodeReady = 1'b0;
	endtask

	initial begin
		opWordT ctrl;
		arstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 2'd0;
		wbDatW = '0;
		decodeReady = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		checkFlag("wbAck after reset", wbAck, 1'b0);
		checkFlag("decodeValid after reset", decodeValid, 1'b0);
		wbRead(ADDR_CTRL, ctrl);
		checkFlag("wxe after reset", ctrl[0], 1'b0);
		checkFlag("queue full after reset", ctrl[1], 1'b0);
		fork
			produce();
			consume();
		join
		if (expQ.size() == 0 && popped == PASSES * NCASES) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			stopOnError("Bundles were written but never decoded");
		end
	end

endmodule

/* dv/wexDecode_assertions.sv */
/*
 Concurrent checks bound into wexDecodeTop.
 Output stability covers opCount and every lane field.
 */
module wexDecodeAssertions (
	input logic clock,
	input logic arstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic decodeReady,
	input logic decodeValid,
	input wexPkg::opCountT opCount,
	input wexPkg::regIdT regAM, regAO, regAN,
	input wexPkg::regIdT regBM, regBO, regBN,
	input wexPkg::regIdT regCM, regCO, regCN,
	input wexPkg::immT immA, immB, immC,
	input wexPkg::uCmdT uCmdA, uCmdB, uCmdC,
	input wexPkg::uIxtT uIxtA, uIxtB, uIxtC
);
	timeunit 1ns;
	timeprecision 100ps;

	ackInCycle: assert property (@(posedge clock) disable iff (!arstN)
		wbAck |-> (wbCyc && wbStb))
		else $error("wbAck without an active cycle");

	validInReset: assert property (@(posedge clock) !arstN |-> !decodeValid)
		else $error("decodeValid high during reset");

	// Stalled bundle must not change
	outputsHeld: assert property (@(posedge clock) disable iff (!arstN)
		(decodeValid && !decodeReady) |=> decodeValid && $stable({opCount,
		regAM, regAO, regAN, regBM, regBO, regBN, regCM, regCO, regCN,
		immA, immB, immC, uCmdA, uCmdB, uCmdC, uIxtA, uIxtB, uIxtC}))
		else $error("Decoded output changed while stalled");

endmodule

bind wexDecodeTop wexDecodeAssertions uAssertions (.*);

/* rtl/wexDecodeTop.sv */
/*
 WEX decode stage. Wishbone classic write port in, registered decoded lanes out.
 Commit ack to decodeValid is 2 cycles when queue and output are free.
 */
module wexDecodeTop (
	input logic clock,
	input logic arstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [1:0] wbAdr,
	input wexPkg::opWordT wbDatW,
	output wexPkg::opWordT wbDatR,
	output logic wbAck,
	input logic decodeReady,
	output logic decodeValid,
	output wexPkg::opCountT opCount,
	output wexPkg::regIdT regAM, regAO, regAN,
	output wexPkg::regIdT regBM, regBO, regBN,
	output wexPkg::regIdT regCM, regCO, regCN,
	output wexPkg::immT immA, immB, immC,
	output wexPkg::uCmdT uCmdA, uCmdB, uCmdC,
	output wexPkg::uIxtT uIxtA, uIxtB, uIxtC
);

	logic queueFull;

	bundleStreamIf wrToQueue ();
	bundleStreamIf queueToDec ();

	wbBundleWriter uWriter (
		.clock,
		.arstN,
		.wbCyc,
		.wbStb,
		.wbWe,
		.wbAdr,
		.wbDatW,
		.queueFull,
		.wbDatR,
		.wbAck,
		.wxeOut(),	// Readable through the control register
		.bundleOut(wrToQueue)
	);

	bundleQueue uQueue (
		.clock,
		.arstN,
		.inBundle(wrToQueue),
		.outBundle(queueToDec),
		.full(queueFull)
	);

	bundleDecode uDecode (
		.*,
		.inBundle(queueToDec)
	);

endmodule

/* rtl/bundleDecode.sv */
/*
 Routes up to three decoded ops into lanes A/B/C and registers the result.
 In a WEX chain the last op lands in lane A. Idle lanes carry ZZR fields.
 Output holds while decodeValid is high and decodeReady is low.
 */
module bundleDecode (
	input logic clock,
	input logic arstN,
	input logic decodeReady,
	bundleStreamIf.sink inBundle,
	output logic decodeValid,
	output wexPkg::opCountT opCount,
	output wexPkg::regIdT regAM, regAO, regAN,
	output wexPkg::regIdT regBM, regBO, regBN,
	output wexPkg::regIdT regCM, regCO, regCN,
	output wexPkg::immT immA, immB, immC,
	output wexPkg::uCmdT uCmdA, uCmdB, uCmdC,
	output wexPkg::uIxtT uIxtA, uIxtB, uIxtC
);
	import wexPkg::*;

	regIdT dRegN [LANES];
	regIdT dRegM [LANES];
	regIdT dRegO [LANES];
	immT dImm [LANES];
	uCmdT dCmd [LANES];
	uIxtT dIxt [LANES];
	logic dWex [LANES];

	logic [1:0] src [LANES];
	logic used [LANES];
	regIdT idleM [LANES];
	regIdT idleO [LANES];

	regIdT nRegN [LANES];
	regIdT nRegM [LANES];
	regIdT nRegO [LANES];
	immT nImm [LANES];
	uCmdT nCmd [LANES];
	uIxtT nIxt [LANES];
	opCountT nCount;

	logic wA;
	logic wB;
	logic load;

	for (genvar i = 0; i < LANES; i++) begin : gLane
		laneDecode uLaneDecode (
			.word(inBundle.bundle[i*$bits(opWordT) +: $bits(opWordT)]),
			.regN(dRegN[i]),
			.regM(dRegM[i]),
			.regO(dRegO[i]),
			.imm(dImm[i]),
			.uCmd(dCmd[i]),
			.uIxt(dIxt[i]),
			.isUncondWex(dWex[i])
		);
	end

	assign wA = dWex[0] && inBundle.wxe;
	assign wB = dWex[1] && inBundle.wxe;

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			src[l] = 2'd0;
			used[l] = 1'b0;
			idleM[l] = GR_ZZR;
			idleO[l] = GR_ZZR;
		end
		nCount = 2'd1;
		if (wA && wB) begin
			src[0] = 2'd2;
			src[1] = 2'd1;
			used[0] = 1'b1;
			used[1] = 1'b1;
			used[2] = 1'b1;
			nCount = 2'd3;
		end else if (wA) begin
			src[0] = 2'd1;	// Word1 ends the chain
			used[0] = 1'b1;
			used[1] = 1'b1;
			idleM[2] = dRegN[0];
			idleO[2] = dRegN[1];
			nCount = 2'd2;
		end else begin
			used[0] = 1'b1;
			idleO[1] = dRegN[0];
			idleO[2] = dRegN[0];
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			if (used[l]) begin
				nRegN[l] = dRegN[src[l]];
				nRegM[l] = dRegM[src[l]];
				nRegO[l] = dRegO[src[l]];
				nImm[l] = dImm[src[l]];
				nCmd[l] = dCmd[src[l]];
				nIxt[l] = dIxt[src[l]];
			end else begin
				nRegN[l] = GR_ZZR;
				nRegM[l] = idleM[l];
				nRegO[l] = idleO[l];
				nImm[l] = '0;
				nCmd[l] = '0;
				nIxt[l] = '0;
			end
		end
	end

	assign inBundle.ready = !decodeValid || decodeReady;
	assign load = inBundle.valid && inBundle.ready;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			decodeValid <= 1'b0;
		end else if (load) begin
			decodeValid <= 1'b1;
		end else if (decodeReady) begin
			decodeValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			opCount <= nCount;
			regAN <= nRegN[0];
			regAM <= nRegM[0];
			regAO <= nRegO[0];
			immA <= nImm[0];
			uCmdA <= nCmd[0];
			uIxtA <= nIxt[0];
			regBN <= nRegN[1];
			regBM <= nRegM[1];
			regBO <= nRegO[1];
			immB <= nImm[1];
			uCmdB <= nCmd[1];
			uIxtB <= nIxt[1];
			regCN <= nRegN[2];
			regCM <= nRegM[2];
			regCO <= nRegO[2];
			immC <= nImm[2];
			uCmdC <= nCmd[2];
			uIxtC <= nIxt[2];
		end
	end

endmodule

/* rtl/laneDecode.sv */
/*
 Combinational decode of one 32-bit op word.
 isUncondWex ignores the bundle's wxe bit; the bundle decoder gates it.
 */
module laneDecode (
	input wexPkg::opWordT word,
	output wexPkg::regIdT regN,
	output wexPkg::regIdT regM,
	output wexPkg::regIdT regO,
	output wexPkg::immT imm,
	output wexPkg::uCmdT uCmd,
	output wexPkg::uIxtT uIxt,
	output logic isUncondWex
);
	import wexPkg::*;

	logic isPred;
	logic isUncond;
	condT cond;

	assign isPred = (word[31:27] == PFX_PRED[5:1]);
	assign isUncond = (word[31:27] == PFX_UNCOND[5:1]);

	assign regN = word[25:20];
	assign regM = word[19:14];
	assign regO = word[13:8];
	assign imm = {{19{word[13]}}, word[13:0]};	// Sign extend to 33 bits
	assign uIxt = word[7:0];

	always_comb begin
		if (isPred) begin
			cond = word[26] ? COND_CF : COND_CT;	// Bit 26 picks predicate-false
		end else begin
			cond = COND_AL;
		end
	end

	assign uCmd = {cond, word[5:0]};
	assign isUncondWex = isUncond && word[26];

endmodule

/* rtl/bundleQueue.sv */
/*
 Circular FIFO of committed bundles, QUEUE_DEPTH entries, no bypass.
 A pushed entry appears at the output after the push edge.
 */
module bundleQueue (
	input logic clock,
	input logic arstN,
	bundleStreamIf.sink inBundle,
	bundleStreamIf.source outBundle,
	output logic full
);
	import wexPkg::*;

	bundleWordT memBundle [QUEUE_DEPTH];
	logic memWxe [QUEUE_DEPTH];
	qPtrT wrPtr;
	qPtrT rdPtr;
	qCountT count;
	logic push;
	logic pop;

	function automatic qPtrT nextPtr(input qPtrT ptr);
		return (ptr == qPtrT'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == qCountT'(QUEUE_DEPTH));
	assign inBundle.ready = !full;
	assign outBundle.valid = (count != '0);
	assign push = inBundle.valid && !full;
	assign pop = outBundle.valid && outBundle.ready;

	assign outBundle.bundle = memBundle[rdPtr];
	assign outBundle.wxe = memWxe[rdPtr];

	always_ff @(posedge clock) begin
		if (push) begin
			memBundle[wrPtr] <= inBundle.bundle;
			memWxe[wrPtr] <= inBundle.wxe;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

endmodule

/* rtl/wbBundleWriter.sv */
/*
 Wishbone classic slave gathering three op words into a bundle.
 Word2 is not stored; the address-2 write commits it straight from the bus.
 A commit write stalls without ack until the queue has room.
 Master must hold cyc, stb, we, adr and data until ack.
 */
module wbBundleWriter (
	input logic clock,
	input logic arstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [1:0] wbAdr,
	input wexPkg::opWordT wbDatW,
	input logic queueFull,
	output wexPkg::opWordT wbDatR,
	output logic wbAck,
	output logic wxeOut,
	bundleStreamIf.source bundleOut
);
	import wexPkg::*;

	opWordT word0;
	opWordT word1;
	logic wxe;
	logic request;
	logic commitReq;
	logic wrEdge;

	assign request = wbCyc && wbStb && !wbAck;
	assign commitReq = wbWe && (wbAdr == ADDR_COMMIT);
	assign wrEdge = wbAck && wbWe;	// Writes land on the ack edge

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= request && (!commitReq || bundleOut.ready);
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wxe <= 1'b0;
		end else if (wrEdge && (wbAdr == ADDR_CTRL)) begin
			wxe <= wbDatW[0];
		end
	end

	always_ff @(posedge clock) begin
		if (wrEdge && (wbAdr == 2'd0)) begin
			word0 <= wbDatW;
		end
		if (wrEdge && (wbAdr == 2'd1)) begin
			word1 <= wbDatW;
		end
	end

	assign wbDatR = (wbAdr == ADDR_CTRL) ? {30'b0, queueFull, wxe} : '0;

	// Push happens on the ack edge of the commit write
	assign bundleOut.valid = wbAck && commitReq;
	assign bundleOut.bundle = {wbDatW, word1, word0};
	assign bundleOut.wxe = wxe;
	assign wxeOut = wxe;

endmodule

/* rtl/bundleStreamIf.sv */
/*
 One fetch window with its wide-execute bit and a valid/ready handshake.
 Valid and payload hold until the transfer edge.
 */
interface bundleStreamIf;
	import wexPkg::*;

	logic valid;
	logic ready;
	bundleWordT bundle;
	logic wxe;

	modport source (output valid, output bundle, output wxe, input ready);
	modport sink (input valid, input bundle, input wxe, output ready);

endinterface

/* rtl/wexPkg.sv */
/*
 Shared widths, types and constants of the WEX decode stage.
 Op prefixes are matched on bits 31:27 only; bit 26 is the per-class flag.
 QUEUE_DEPTH must be at least 2.
 */
package wexPkg;

	typedef logic [5:0] regIdT;
	typedef logic [32:0] immT;
	typedef logic [7:0] uCmdT;	// 7:6 condition, 5:0 operation
	typedef logic [7:0] uIxtT;
	typedef logic [31:0] opWordT;
	typedef logic [95:0] bundleWordT;	// Word0 in bits 31:0
	typedef logic [1:0] opCountT;
	typedef logic [1:0] condT;

	localparam regIdT GR_ZZR = 6'd63;

	localparam condT COND_AL = 2'd0;
	localparam condT COND_CT = 2'd2;
	localparam condT COND_CF = 2'd3;

	localparam int LANES = 3;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	typedef logic [QUEUE_PTR_W-1:0] qPtrT;
	typedef logic [$clog2(QUEUE_DEPTH + 1)-1:0] qCountT;

	localparam logic [1:0] ADDR_COMMIT = 2'd2;
	localparam logic [1:0] ADDR_CTRL = 2'd3;

	// Low bit of each pattern is the flag position
	localparam logic [5:0] PFX_PRED = 6'b111000;
	localparam logic [5:0] PFX_UNCOND = 6'b111100;

endpackage
